/* design/eai_macros.svh */
// eai accelerator constants: word widths, custom-0 encodings and matrix geometry
`ifndef EAI_MACROS_SVH
`define EAI_MACROS_SVH

// datapath widths
`define EAI_XLEN        32
`define EAI_ADDR_SIZE   32

// instruction field slices
`define EAI_INST_OPCODE 6:0
`define EAI_INST_F3     14:12
`define EAI_INST_F7     31:25

// custom-0 major opcode
`define EAI_OPCODE_CUSTOM0 7'b0001011

// func3 / func7 codes
`define EAI_F3_SETUP    3'b011
`define EAI_F3_SUM      3'b110
`define EAI_F7_SETUP    7'b0000000
`define EAI_F7_ROWSUM   7'b0000001
`define EAI_F7_COLSUM   7'b0000010

// matrix geometry
`define EAI_ROW_WORDS   3
`define EAI_COL_IDX_W   2
// byte step between consecutive words of a row
`define EAI_WORD_BYTES  4

`endif

/* design/eai_pkg.sv */
// eai shared types for the request, response and memory command channels
`include "eai_macros.svh"

package eai_pkg;

   // instruction plus both source operands from the core
   typedef struct packed {
      logic [`EAI_XLEN-1:0] inst;
      logic [`EAI_XLEN-1:0] rs1;
      logic [`EAI_XLEN-1:0] rs2;
   } eai_req_t;

   // result word, err set for an unknown instruction
   typedef struct packed {
      logic                 err;
      logic [`EAI_XLEN-1:0] rdat;
   } eai_rsp_t;

   // word read only
   typedef struct packed {
      logic [`EAI_ADDR_SIZE-1:0] addr;
   } icb_cmd_t;

   // decoded operation
   typedef enum logic [2:0] {
      op_none,
      op_setup,
      op_rowsum,
      op_colsum,
      op_illegal
   } eai_op_e;

endpackage

/* design/eai_hold_reg.sv */
// output holding register for a valid/ready channel, keeps the payload until taken
`timescale 1ns/10ps

module eai_hold_reg #(
   parameter type payload_t = logic
) (
   input  logic     eai_clk,
   input  logic     reset,
   input  logic     load,
   input  payload_t load_data,
   output logic     valid,
   output payload_t data,
   input  logic     ready,
   output logic     busy
);

   logic     valid_r;
   payload_t data_r;

   always_ff @(posedge eai_clk) begin
      if (reset) begin
         valid_r <= 1'b0;
      end else if (load) begin
         valid_r <= 1'b1;
      end else if (ready) begin
         valid_r <= 1'b0;
      end
   end

   always_ff @(posedge eai_clk) begin
      if (load) begin
         data_r <= load_data;
      end
   end

   assign valid = valid_r;
   assign data  = data_r;
   assign busy  = valid_r;

   // producer must wait until the previous payload has been taken
   assert property (@(posedge eai_clk) disable iff (reset) !(load && valid_r && !ready));

endmodule

/* design/eai_ctrl.sv */
// eai controller: custom-0 decode, matrix setup registers and operation sequencing
`timescale 1ns/10ps
`include "eai_macros.svh"

module eai_ctrl import eai_pkg::*; (
   input  logic                      eai_clk,
   input  logic                      reset,
   // request channel
   input  logic                      req_valid,
   input  eai_req_t                  req,
   output logic                      req_ready,
   // response holder
   output logic                      rsp_load,
   output eai_rsp_t                  rsp_data,
   input  logic                      rsp_busy,
   // row fetch
   output logic                      row_start,
   output logic [`EAI_ADDR_SIZE-1:0] row_addr,
   input  logic                      row_done,
   input  logic [`EAI_XLEN-1:0]      row_sum,
   // column buffer
   output logic                      first_row,
   output logic [`EAI_XLEN-1:0]      col_idx,
   input  logic [`EAI_XLEN-1:0]      col_value,
   output logic                      mem_holdup
);

   typedef enum logic [1:0] {st_idle, st_row, st_drain} state_e;

   state_e                    state_r;
   state_e                    state_nxt;
   eai_op_e                   op;
   logic                      req_hsk;
   logic [`EAI_ADDR_SIZE-1:0] base_r;
   logic [`EAI_XLEN-1:0]      stride_r;
   logic                      first_row_r;

   ////////////////////////////////////////
   // decode
   ////////////////////////////////////////
   always_comb begin
      op = op_none;
      if (req_valid) begin
         op = op_illegal;
         if (req.inst[`EAI_INST_OPCODE] == `EAI_OPCODE_CUSTOM0) begin
            case ({req.inst[`EAI_INST_F3], req.inst[`EAI_INST_F7]})
               {`EAI_F3_SETUP, `EAI_F7_SETUP}:  op = op_setup;
               {`EAI_F3_SUM,   `EAI_F7_ROWSUM}: op = op_rowsum;
               {`EAI_F3_SUM,   `EAI_F7_COLSUM}: op = op_colsum;
               default:                         op = op_illegal;
            endcase
         end
      end
   end

   assign req_ready = (state_r == st_idle);
   assign req_hsk   = req_valid & req_ready;

   // matrix base and row stride in words
   always_ff @(posedge eai_clk) begin
      if (reset) begin
         base_r   <= '0;
         stride_r <= '0;
      end else if (req_hsk && op == op_setup) begin
         base_r   <= req.rs1;
         stride_r <= req.rs2;
      end
   end

   // row 0 reloads the column buffer
   always_ff @(posedge eai_clk) begin
      if (reset) begin
         first_row_r <= 1'b0;
      end else if (row_start) begin
         first_row_r <= (req.rs1 == '0);
      end
   end

   ////////////////////////////////////////
   // FSM
   ////////////////////////////////////////
   always_comb begin
      state_nxt = state_r;
      case (state_r)
         st_idle:  if (req_hsk) state_nxt = (op == op_rowsum) ? st_row : st_drain;
         st_row:   if (row_done) state_nxt = st_drain;
         st_drain: if (!rsp_busy) state_nxt = st_idle;
         default:  state_nxt = st_idle;
      endcase
   end

   always_ff @(posedge eai_clk) begin
      if (reset) begin
         state_r <= st_idle;
      end else begin
         state_r <= state_nxt;
      end
   end

   assign row_start  = req_hsk & (op == op_rowsum);
   assign row_addr   = base_r + req.rs1 * stride_r * `EAI_WORD_BYTES;
   assign first_row  = first_row_r;
   assign col_idx    = req.rs1;
   assign mem_holdup = (state_r == st_row);

   // response payload
   always_comb begin
      rsp_load = 1'b0;
      rsp_data = '0;
      if (state_r == st_row) begin
         rsp_load      = row_done;
         rsp_data.rdat = row_sum;
      end else if (req_hsk) begin
         rsp_load = (op != op_rowsum);
         case (op)
            op_colsum:  rsp_data.rdat = col_value;
            op_illegal: rsp_data.err  = 1'b1;
            default:    rsp_data.rdat = '0;
         endcase
      end
   end

   // row results arrive only while a rowsum is in flight
   assert property (@(posedge eai_clk) disable iff (reset)
      row_done |-> (state_r == st_row));

endmodule

/* design/eai_row_fetch.sv */
// row fetch: reads the words of one matrix row and sums them
`timescale 1ns/10ps
`include "eai_macros.svh"

module eai_row_fetch import eai_pkg::*; (
   input  logic                      eai_clk,
   input  logic                      reset,
   input  logic                      row_start,
   input  logic [`EAI_ADDR_SIZE-1:0] row_addr,
   // command holder
   output logic                      cmd_load,
   output icb_cmd_t                  cmd_data,
   input  logic                      cmd_busy,
   // memory response
   input  logic                      icb_rsp_valid,
   input  logic [`EAI_XLEN-1:0]      icb_rsp_rdata,
   // word strobe and row result
   output logic                      word_valid,
   output logic [`EAI_COL_IDX_W-1:0] word_idx,
   output logic                      row_done,
   output logic [`EAI_XLEN-1:0]      row_sum
);

   logic                      busy_r;
   logic [`EAI_COL_IDX_W-1:0] cnt_r;
   logic [`EAI_ADDR_SIZE-1:0] addr_r;
   logic [`EAI_XLEN-1:0]      sum_r;
   logic                      done_r;
   logic                      last_word;

   assign last_word  = (cnt_r == `EAI_COL_IDX_W'(`EAI_ROW_WORDS - 1));
   assign word_valid = icb_rsp_valid & busy_r;
   assign word_idx   = cnt_r;

   // first read comes straight from the row address
   assign cmd_load      = row_start | (word_valid & ~last_word);
   assign cmd_data.addr = row_start ? row_addr : addr_r;

   always_ff @(posedge eai_clk) begin
      if (reset) begin
         busy_r <= 1'b0;
         cnt_r  <= '0;
         done_r <= 1'b0;
      end else begin
         done_r <= 1'b0;
         if (row_start) begin
            busy_r <= 1'b1;
            cnt_r  <= '0;
         end else if (word_valid) begin
            cnt_r <= cnt_r + 1'b1;
            if (last_word) begin
               busy_r <= 1'b0;
               done_r <= 1'b1;
            end
         end
      end
   end

   // next read address and running sum
   always_ff @(posedge eai_clk) begin
      if (row_start) begin
         addr_r <= row_addr + `EAI_WORD_BYTES;
         sum_r  <= '0;
      end else if (word_valid) begin
         addr_r <= addr_r + `EAI_WORD_BYTES;
         sum_r  <= sum_r + icb_rsp_rdata;
      end
   end

   assign row_done = done_r;
   assign row_sum  = sum_r;

   // data only for a row in flight, after its read has left the holder
   assert property (@(posedge eai_clk) disable iff (reset)
      icb_rsp_valid |-> busy_r && !cmd_busy);

endmodule

/* design/eai_col_buf.sv */
// column buffer: per-column running totals over the rows read so far
`timescale 1ns/10ps
`include "eai_macros.svh"

module eai_col_buf (
   input  logic                      eai_clk,
   input  logic                      reset,
   // row words
   input  logic                      word_valid,
   input  logic [`EAI_COL_IDX_W-1:0] word_idx,
   input  logic [`EAI_XLEN-1:0]      word_data,
   input  logic                      first_row,
   // column read-out
   input  logic [`EAI_XLEN-1:0]      col_idx,
   output logic [`EAI_XLEN-1:0]      col_value
);

   logic [`EAI_XLEN-1:0] acc_r [`EAI_ROW_WORDS];

   ////////////////////////////////////////
   // accumulate
   ////////////////////////////////////////
   always_ff @(posedge eai_clk) begin
      if (reset) begin
         for (int i = 0; i < `EAI_ROW_WORDS; i++) begin
            acc_r[i] <= '0;
         end
      end else if (word_valid) begin
         // row 0 starts a fresh set of totals
         if (first_row) begin
            acc_r[word_idx] <= word_data;
         end else begin
            acc_r[word_idx] <= acc_r[word_idx] + word_data;
         end
      end
   end

   ////////////////////////////////////////
   // read-out
   ////////////////////////////////////////
   assign col_value = (col_idx < `EAI_ROW_WORDS) ? acc_r[col_idx[`EAI_COL_IDX_W-1:0]] : '0;

   // word index from the row fetch counter stays inside the buffer
   assert property (@(posedge eai_clk) disable iff (reset)
      word_valid |-> (word_idx < `EAI_ROW_WORDS));

endmodule

/* design/eai_core.sv */
// eai core top: request/response and memory read channels around the reduction blocks
`timescale 1ns/10ps
`include "eai_macros.svh"

module eai_core import eai_pkg::*; (
   input  logic                 eai_clk,
   input  logic                 reset,
   // request
   input  logic                 req_valid,
   output logic                 req_ready,
   input  eai_req_t             req,
   // response
   output logic                 rsp_valid,
   input  logic                 rsp_ready,
   output eai_rsp_t             rsp,
   // memory command
   output logic                 icb_cmd_valid,
   input  logic                 icb_cmd_ready,
   output icb_cmd_t             icb_cmd,
   // memory response
   input  logic                 icb_rsp_valid,
   input  logic [`EAI_XLEN-1:0] icb_rsp_rdata,
   output logic                 mem_holdup
);

   logic                      rsp_load;
   eai_rsp_t                  rsp_data;
   logic                      rsp_busy;
   logic                      row_start;
   logic [`EAI_ADDR_SIZE-1:0] row_addr;
   logic                      row_done;
   logic [`EAI_XLEN-1:0]      row_sum;
   logic                      first_row;
   logic [`EAI_XLEN-1:0]      col_idx;
   logic [`EAI_XLEN-1:0]      col_value;
   logic                      cmd_load;
   icb_cmd_t                  cmd_data;
   logic                      cmd_busy;
   logic                      word_valid;
   logic [`EAI_COL_IDX_W-1:0] word_idx;

   eai_ctrl u_ctrl (
      .eai_clk    (eai_clk),
      .reset      (reset),
      .req_valid  (req_valid),
      .req        (req),
      .req_ready  (req_ready),
      .rsp_load   (rsp_load),
      .rsp_data   (rsp_data),
      .rsp_busy   (rsp_busy),
      .row_start  (row_start),
      .row_addr   (row_addr),
      .row_done   (row_done),
      .row_sum    (row_sum),
      .first_row  (first_row),
      .col_idx    (col_idx),
      .col_value  (col_value),
      .mem_holdup (mem_holdup)
   );

   eai_row_fetch u_row_fetch (
      .eai_clk       (eai_clk),
      .reset         (reset),
      .row_start     (row_start),
      .row_addr      (row_addr),
      .cmd_load      (cmd_load),
      .cmd_data      (cmd_data),
      .cmd_busy      (cmd_busy),
      .icb_rsp_valid (icb_rsp_valid),
      .icb_rsp_rdata (icb_rsp_rdata),
      .word_valid    (word_valid),
      .word_idx      (word_idx),
      .row_done      (row_done),
      .row_sum       (row_sum)
   );

   eai_col_buf u_col_buf (
      .eai_clk    (eai_clk),
      .reset      (reset),
      .word_valid (word_valid),
      .word_idx   (word_idx),
      .word_data  (icb_rsp_rdata),
      .first_row  (first_row),
      .col_idx    (col_idx),
      .col_value  (col_value)
   );

   // response toward the core
   eai_hold_reg #(.payload_t(eai_rsp_t)) u_rsp_hold (
      .eai_clk   (eai_clk),
      .reset     (reset),
      .load      (rsp_load),
      .load_data (rsp_data),
      .valid     (rsp_valid),
      .data      (rsp),
      .ready     (rsp_ready),
      .busy      (rsp_busy)
   );

   // read command toward memory
   eai_hold_reg #(.payload_t(icb_cmd_t)) u_cmd_hold (
      .eai_clk   (eai_clk),
      .reset     (reset),
      .load      (cmd_load),
      .load_data (cmd_data),
      .valid     (icb_cmd_valid),
      .data      (icb_cmd),
      .ready     (icb_cmd_ready),
      .busy      (cmd_busy)
   );

endmodule

/* tests/tb_eai_core.sv */
// eai core testbench: random matrix reductions against a reference model with stalled channels
`timescale 1ns/10ps
`include "eai_macros.svh"

module tb_eai_core import eai_pkg::*; ();

   localparam int max_wait = 200;

   logic                 eai_clk;
   logic                 reset;
   logic                 req_valid;
   logic                 req_ready;
   eai_req_t             req;
   logic                 rsp_valid;
   logic                 rsp_ready;
   eai_rsp_t             rsp;
   logic                 icb_cmd_valid;
   logic                 icb_cmd_ready;
   icb_cmd_t             icb_cmd;
   logic                 icb_rsp_valid;
   logic [`EAI_XLEN-1:0] icb_rsp_rdata;
   logic                 mem_holdup;

   // reference model state
   logic [31:0] m_base;
   logic [31:0] m_stride;
   logic [31:0] m_col [`EAI_ROW_WORDS];
   logic [31:0] cmd_addr_q [$];

   eai_core i_dut (.*);

   initial eai_clk = 1'b0;
   always #50 eai_clk = ~eai_clk;

   ////////////////////////////////////////
   // helpers
   ////////////////////////////////////////
   task automatic stop_run(string what);
      $display("%s", what);
      $display("TESTS FAILED");
      $fatal(1, "simulation stopped at first error");
   endtask

   task automatic check_value(string name, logic [63:0] actual, logic [63:0] expected);
      if (actual !== expected) begin
         stop_run($sformatf("error at %0d ns: %s is %0h, expected %0h",
                            $time, name, actual, expected));
      end
   endtask

   // memory content, a hash of the full address
   function automatic logic [31:0] mem_word(logic [31:0] addr);
      return (addr * 32'h9e37_79b1) ^ {addr[15:0], addr[31:16]} ^ 32'h6d2b_79f5;
   endfunction

   function automatic logic is_legal(logic [31:0] inst);
      logic [2:0] f3;
      logic [6:0] f7;
      f3 = inst[14:12];
      f7 = inst[31:25];
      if (inst[6:0] != `EAI_OPCODE_CUSTOM0) begin
         return 1'b0;
      end
      return (f3 == `EAI_F3_SETUP && f7 == `EAI_F7_SETUP) ||
             (f3 == `EAI_F3_SUM && (f7 == `EAI_F7_ROWSUM || f7 == `EAI_F7_COLSUM));
   endfunction

   function automatic logic [31:0] make_inst(logic [2:0] f3, logic [6:0] f7);
      logic [31:0] inst;
      inst = $urandom;
      inst[6:0]   = `EAI_OPCODE_CUSTOM0;
      inst[14:12] = f3;
      inst[31:25] = f7;
      return inst;
   endfunction

   ////////////////////////////////////////
   // request and response channels
   ////////////////////////////////////////
   task automatic send_req(logic [31:0] inst, logic [31:0] rs1, logic [31:0] rs2,
                           logic is_row, logic [31:0] row_addr);
      int cycles;
      cycles = 0;
      repeat ($urandom_range(2, 0)) @(negedge eai_clk);
      @(negedge eai_clk);
      rsp_ready = 1'b0;
      while (!req_ready) begin
         cycles++;
         if (cycles > max_wait) stop_run("timeout waiting for req_ready");
         @(negedge eai_clk);
      end
      req_valid = 1'b1;
      req.inst  = inst;
      req.rs1   = rs1;
      req.rs2   = rs2;
      @(negedge eai_clk);
      req_valid = 1'b0;
      check_value("req_ready", req_ready, 0);
      if (is_row) begin
         check_value("icb_cmd_valid", icb_cmd_valid, 1);
         check_value("icb_cmd.addr", icb_cmd.addr, row_addr);
         check_value("mem_holdup", mem_holdup, 1);
      end else begin
         check_value("rsp_valid", rsp_valid, 1);
         check_value("icb_cmd_valid", icb_cmd_valid, 0);
      end
   endtask

   // random back-pressure, the held response must not move
   task automatic take_response(output eai_rsp_t r);
      int       cycles;
      logic     held;
      logic     done;
      eai_rsp_t seen;
      cycles = 0;
      held   = 1'b0;
      done   = 1'b0;
      seen   = '0;
      while (!done) begin
         @(negedge eai_clk);
         rsp_ready = 1'b0;
         if (held) check_value("rsp_valid", rsp_valid, 1);
         if (rsp_valid) begin
            check_value("req_ready", req_ready, 0);
            check_value("mem_holdup", mem_holdup, 0);
            if (held) check_value("rsp", rsp, seen);
            if ($urandom_range(2, 0) != 0) begin
               rsp_ready = 1'b1;
               r         = rsp;
               done      = 1'b1;
            end else begin
               held = 1'b1;
               seen = rsp;
            end
         end
         cycles++;
         if (cycles > max_wait) stop_run("timeout waiting for rsp_valid");
      end
      @(negedge eai_clk);
      rsp_ready = 1'b0;
      check_value("rsp_valid", rsp_valid, 0);
   endtask

   ////////////////////////////////////////
   // operations and expected results
   ////////////////////////////////////////
   task automatic do_setup(logic [31:0] base, logic [31:0] stride);
      eai_rsp_t r;
      send_req(make_inst(`EAI_F3_SETUP, `EAI_F7_SETUP), base, stride, 1'b0, '0);
      take_response(r);
      check_value("rsp", r, 33'h0);
      m_base   = base;
      m_stride = stride;
   endtask

   task automatic do_rowsum(logic [31:0] row);
      eai_rsp_t    r;
      logic [31:0] addr;
      logic [31:0] word;
      logic [31:0] sum;
      addr = m_base + row * m_stride * `EAI_WORD_BYTES;
      sum  = '0;
      cmd_addr_q.delete();
      send_req(make_inst(`EAI_F3_SUM, `EAI_F7_ROWSUM), row, $urandom, 1'b1, addr);
      take_response(r);
      check_value("read count", cmd_addr_q.size(), `EAI_ROW_WORDS);
      for (int k = 0; k < `EAI_ROW_WORDS; k++) begin
         check_value("icb_cmd.addr", cmd_addr_q[k], addr + k * `EAI_WORD_BYTES);
         word = mem_word(addr + k * `EAI_WORD_BYTES);
         sum  = sum + word;
         // row 0 restarts the column totals
         m_col[k] = (row == 0) ? word : m_col[k] + word;
      end
      check_value("rsp.err", r.err, 0);
      check_value("rsp.rdat", r.rdat, sum);
   endtask

   task automatic do_colsum(logic [31:0] idx);
      eai_rsp_t    r;
      logic [31:0] expected;
      expected = (idx < `EAI_ROW_WORDS) ? m_col[idx] : '0;
      send_req(make_inst(`EAI_F3_SUM, `EAI_F7_COLSUM), idx, $urandom, 1'b0, '0);
      take_response(r);
      check_value("rsp", r, {1'b0, expected});
   endtask

   task automatic do_illegal();
      eai_rsp_t    r;
      logic [31:0] inst;
      inst = $urandom;
      if ($urandom_range(1, 0)) inst[6:0] = `EAI_OPCODE_CUSTOM0;
      if ($urandom_range(1, 0)) inst[14:12] = `EAI_F3_SUM;
      if (is_legal(inst)) inst[25] = ~inst[25];
      cmd_addr_q.delete();
      send_req(inst, $urandom, $urandom, 1'b0, '0);
      take_response(r);
      check_value("rsp.err", r.err, 1);
      check_value("read count", cmd_addr_q.size(), 0);
   endtask

   ////////////////////////////////////////
   // memory model
   ////////////////////////////////////////
   initial begin : memory_model
      logic        pending;
      logic [31:0] pend_addr;
      int          delay;
      pending   = 1'b0;
      pend_addr = '0;
      delay     = 0;
      forever begin
         @(negedge eai_clk);
         icb_rsp_valid = 1'b0;
         icb_rsp_rdata = $urandom;
         icb_cmd_ready = ($urandom_range(3, 0) != 0);
         if (!reset) begin
            if (icb_cmd_valid && !mem_holdup) stop_run("memory read issued outside a rowsum");
            if (icb_cmd_valid && pending) stop_run("second memory read issued before data returned");
            if (pending) begin
               if (delay == 0) begin
                  icb_rsp_valid = 1'b1;
                  icb_rsp_rdata = mem_word(pend_addr);
                  pending       = 1'b0;
               end else begin
                  delay--;
               end
            end
            if (icb_cmd_valid && icb_cmd_ready) begin
               cmd_addr_q.push_back(icb_cmd.addr);
               pending   = 1'b1;
               pend_addr = icb_cmd.addr;
               delay     = $urandom_range(3, 0);
            end
         end
      end
   end

   ////////////////////////////////////////
   // stimulus
   ////////////////////////////////////////
   initial begin : stimulus
      int row_count;
      void'($urandom(32'h2b5e));
      reset         = 1'b1;
      req_valid     = 1'b0;
      req           = '0;
      rsp_ready     = 1'b0;
      icb_cmd_ready = 1'b0;
      icb_rsp_valid = 1'b0;
      icb_rsp_rdata = '0;
      for (int i = 0; i < `EAI_ROW_WORDS; i++) begin
         m_col[i] = '0;
      end
      m_base   = '0;
      m_stride = '0;
      repeat (2) @(posedge eai_clk);
      @(negedge eai_clk);
      reset = 1'b0;
      check_value("req_ready", req_ready, 1);
      check_value("rsp_valid", rsp_valid, 0);
      check_value("icb_cmd_valid", icb_cmd_valid, 0);
      check_value("mem_holdup", mem_holdup, 0);

      for (int round = 0; round < 5; round++) begin
         do_setup($urandom & 32'hffff_fffc, $urandom_range(64, 1));
         row_count = $urandom_range(8, 3);
         for (int n = 0; n < row_count; n++) begin
            do_rowsum($urandom_range(7, 0));
            if ($urandom_range(3, 0) == 0) do_illegal();
         end
         for (int idx = 0; idx <= `EAI_ROW_WORDS; idx++) begin
            do_colsum(idx);
         end
         do_colsum($urandom | 32'h4);
      end

      // unknown encodings only
      repeat (8) do_illegal();

      $display("TESTS PASSED");
      $finish;
   end

endmodule

/* build.f */
+incdir+design
design/eai_pkg.sv
design/eai_hold_reg.sv
design/eai_ctrl.sv
design/eai_row_fetch.sv
design/eai_col_buf.sv
design/eai_core.sv
tests/tb_eai_core.sv
